//--- Bender.yml
package:
  name: fpu_ctl

sources:
  - rtl/fpu_fmt_pkg.sv
  - rtl/fpu_ctl_pkg.sv
  - rtl/fpu_strobe_gen.sv
  - rtl/fpu_operand_fetch.sv
  - rtl/fpu_sequencer.sv
  - rtl/fpu_mant_alu.sv
  - rtl/fpu_top.sv
  - target: test
    files:
      - tb/fpu_tb_asserts.sv
      - tb/fpu_tb.sv

//--- flist.f
rtl/fpu_fmt_pkg.sv
rtl/fpu_ctl_pkg.sv
rtl/fpu_strobe_gen.sv
rtl/fpu_operand_fetch.sv
rtl/fpu_sequencer.sv
rtl/fpu_mant_alu.sv
rtl/fpu_top.sv
tb/fpu_tb_asserts.sv
tb/fpu_tb.sv

//--- rtl/fpu_ctl_pkg.sv
`default_nettype none

package fpu_ctl_pkg;

	// command opcodes
	typedef enum logic [1:0] {
		op_ld  = 2'd0,
		op_af  = 2'd1,
		op_sf  = 2'd2,
		op_nrf = 2'd3
	} fpu_op_t;

	// strobe timing classes, one per kind of state
	typedef enum logic [1:0] {
		cls_mem   = 2'd0,
		cls_shift = 2'd1,
		cls_add   = 2'd2,
		cls_end   = 2'd3
	} strobe_class_t;

	// delay counter width in the strobe generator
	localparam int dly_w = 4;

	// delay for memory and end classes
	localparam int fixed_dly = 1;

endpackage

`default_nettype wire

//--- rtl/fpu_fmt_pkg.sv
`default_nettype none

package fpu_fmt_pkg;

	// ------------------------------------------------------------------------
	// word and operand layout
	// ------------------------------------------------------------------------

	// memory word, three of them per operand
	localparam int word_w = 16;
	localparam int words_per_op = 3;
	localparam int addr_w = 16;

	// lp counter width, walks the three words
	localparam int idx_w = 2;

	// fraction spans word 1, word 2 and high byte of word 3
	localparam int mant_w = 40;
	localparam int w3_mant_w = mant_w - 2 * word_w;

	// exponent sits in the low byte of word 3
	localparam int exp_w = 8;

	// two's complement exponent range
	localparam logic signed [exp_w-1:0] exp_max = 8'sd127;
	localparam logic signed [exp_w-1:0] exp_min = -8'sd128;

endpackage

`default_nettype wire

//--- rtl/fpu_mant_alu.sv
`default_nettype none

module fpu_mant_alu (
	input logic clk_sys,
	input logic _0_f,
	input logic load_word,
	input logic [fpu_fmt_pkg::idx_w-1:0] word_idx,
	input logic [fpu_fmt_pkg::word_w-1:0] word_data,
	input logic load_acc,
	input logic align_step,
	input logic add_step,
	input logic sub_sel,
	input logic fix_step,
	input logic norm_step,
	output logic exp_equal,
	output logic sum_ovf,
	output logic is_norm,
	output logic [fpu_fmt_pkg::word_w-1:0] res_w1,
	output logic [fpu_fmt_pkg::word_w-1:0] res_w2,
	output logic [fpu_fmt_pkg::word_w-1:0] res_w3,
	output logic res_ovf,
	output logic res_zero
);

	import fpu_fmt_pkg::*;

	logic signed [mant_w-1:0] acc_m, opd_m;
	logic signed [exp_w-1:0] acc_e, opd_e;
	logic [mant_w:0] sum_c, sum_q;
	logic [$clog2(mant_w+1)-1:0] sh_cnt;
	logic acc_smaller, align_go, align_last, acc_zero;

	// ------------------------------------------------------------------------
	// compare and status
	// ------------------------------------------------------------------------

	assign exp_equal = (acc_e == opd_e);
	assign acc_smaller = (acc_e < opd_e);
	assign align_go = align_step & ~exp_equal;
	// fortieth shift, smaller operand is all sign now
	assign align_last = (sh_cnt == ($clog2(mant_w+1))'(mant_w - 1));
	assign acc_zero = (acc_m == '0);
	// top two bits differ, or zero
	assign is_norm = acc_zero | (acc_m[mant_w-1] ^ acc_m[mant_w-2]);

	// 41 bit sum, sign extended inputs
	assign sum_c = sub_sel ? {acc_m[mant_w-1], acc_m} - {opd_m[mant_w-1], opd_m}
		: {acc_m[mant_w-1], acc_m} + {opd_m[mant_w-1], opd_m};
	assign sum_ovf = sum_q[mant_w] ^ sum_q[mant_w-1];

	// result words
	assign res_w1 = acc_m[mant_w-1 -: word_w];
	assign res_w2 = acc_m[mant_w-word_w-1 -: word_w];
	assign res_w3 = {acc_m[w3_mant_w-1:0], acc_e};
	assign res_zero = acc_zero;

	// ------------------------------------------------------------------------
	// accumulator
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f) begin
			acc_m <= '0;
			acc_e <= '0;
			res_ovf <= 1'b0;
		end else if (load_acc) begin
			acc_m <= opd_m;
			acc_e <= opd_e;
			res_ovf <= 1'b0;
		end else if (align_go & acc_smaller) begin
			// truncating shift
			acc_m <= acc_m >>> 1;
			acc_e <= align_last ? opd_e : acc_e + 1'b1;
		end else if (add_step) begin
			acc_m <= sum_c[mant_w-1:0];
			res_ovf <= 1'b0;
		end else if (fix_step) begin
			acc_m <= sum_q[mant_w:1];
			acc_e <= acc_e + 1'b1;
			// exponent wraps past +127
			if (acc_e == exp_max)
				res_ovf <= 1'b1;
		end else if (norm_step) begin
			if (acc_zero)
				acc_e <= '0;
			else if (!is_norm) begin
				// underflow clears the whole number
				if (acc_e == exp_min) begin
					acc_m <= '0;
					acc_e <= '0;
				end else begin
					acc_m <= acc_m <<< 1;
					acc_e <= acc_e - 1'b1;
				end
			end
		end
	end

	// alignment shift count
	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f)
			sh_cnt <= '0;
		else if (load_word)
			sh_cnt <= '0;
		else if (align_go)
			sh_cnt <= sh_cnt + 1'b1;
	end

	// operand register, filled word by word
	always_ff @(posedge clk_sys) begin
		if (load_word) begin
			if (word_idx == idx_w'(0))
				opd_m[mant_w-1 -: word_w] <= word_data;
			else if (word_idx == idx_w'(1))
				opd_m[mant_w-word_w-1 -: word_w] <= word_data;
			else begin
				opd_m[w3_mant_w-1:0] <= word_data[word_w-1 -: w3_mant_w];
				opd_e <= word_data[exp_w-1:0];
			end
		end else if (align_go & ~acc_smaller) begin
			opd_m <= opd_m >>> 1;
			opd_e <= align_last ? acc_e : opd_e + 1'b1;
		end
	end

	// raw sum kept for the overflow fix
	always_ff @(posedge clk_sys) begin
		if (add_step)
			sum_q <= sum_c;
	end

endmodule

`default_nettype wire

//--- rtl/fpu_operand_fetch.sv
`default_nettype none

module fpu_operand_fetch (
	input logic clk_sys,
	input logic _0_f,
	input logic fetch_start,
	input logic [fpu_fmt_pkg::addr_w-1:0] fetch_addr,
	input logic mem_req_ready,
	input logic mem_rsp_valid,
	input logic [fpu_fmt_pkg::word_w-1:0] mem_rsp_data,
	output logic mem_req_valid,
	output logic [fpu_fmt_pkg::addr_w-1:0] mem_addr,
	output logic word_valid,
	output logic [fpu_fmt_pkg::idx_w-1:0] word_idx,
	output logic [fpu_fmt_pkg::word_w-1:0] word_data,
	output logic fetch_last
);

	import fpu_fmt_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_req,
		st_wait,
		st_gap
	} fetch_st_t;

	fetch_st_t st;
	logic [idx_w-1:0] lp;
	logic lp_last;
	logic rsp_take;

	// lp at the third word
	assign lp_last = (lp == idx_w'(words_per_op - 1));
	assign rsp_take = (st == st_wait) && mem_rsp_valid;

	// request held until memory takes it
	assign mem_req_valid = (st == st_req);

	// ------------------------------------------------------------------------
	// request sequencing, one read outstanding
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f) begin
			st <= st_idle;
			lp <= '0;
			word_valid <= 1'b0;
			fetch_last <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			fetch_last <= 1'b0;
			unique case (st)
				st_idle: begin
					if (fetch_start) begin
						lp <= '0;
						st <= st_req;
					end
				end
				st_req: begin
					if (mem_req_ready)
						st <= st_wait;
				end
				st_wait: begin
					if (mem_rsp_valid) begin
						word_valid <= 1'b1;
						fetch_last <= lp_last;
						lp <= lp_last ? '0 : lp + 1'b1;
						st <= lp_last ? st_idle : st_gap;
					end
				end
				// one idle clock so the sequencer can take the word
				st_gap: st <= st_req;
			endcase
		end
	end

	// address and word payload
	always_ff @(posedge clk_sys) begin
		if ((st == st_idle) && fetch_start)
			mem_addr <= fetch_addr;
		else if (rsp_take)
			mem_addr <= mem_addr + 1'b1;
		if (rsp_take) begin
			word_data <= mem_rsp_data;
			word_idx <= lp;
		end
	end

endmodule

`default_nettype wire

//--- rtl/fpu_sequencer.sv
`default_nettype none

module fpu_sequencer (
	input logic clk_sys,
	input logic _0_f,
	input logic cmd_valid,
	input fpu_ctl_pkg::fpu_op_t cmd_op,
	input logic [fpu_fmt_pkg::addr_w-1:0] cmd_addr,
	input logic done_ready,
	input logic strob1,
	input logic strob2,
	input logic word_valid,
	input logic fetch_last,
	input logic exp_equal,
	input logic sum_ovf,
	input logic is_norm,
	output logic cmd_ready,
	output logic done_valid,
	output logic state_entry,
	output fpu_ctl_pkg::strobe_class_t state_class,
	output logic fetch_start,
	output logic [fpu_fmt_pkg::addr_w-1:0] fetch_addr,
	output logic load_word,
	output logic align_step,
	output logic add_step,
	output logic fix_step,
	output logic norm_step,
	output logic sub_sel,
	output logic load_acc
);

	import fpu_ctl_pkg::*;

	// state flags
	logic f_fetch, f_align, f_add, f_fix, f_norm, f_end;
	logic ef_fetch, ef_align, ef_add, ef_fix, ef_norm, ef_end;
	fpu_op_t op_q;
	logic last_seen;
	logic accept;
	logic is_ld;
	logic fetch_done;

	// idle when no flag is up
	assign cmd_ready = ~(f_fetch | f_align | f_add | f_fix | f_norm | f_end);
	assign accept = cmd_valid & cmd_ready;
	assign done_valid = f_end;

	assign is_ld = (op_q == op_ld);
	assign sub_sel = (op_q == op_sf);
	assign fetch_done = f_fetch & last_seen;

	// ------------------------------------------------------------------------
	// state transitions, taken on strob2
	// ------------------------------------------------------------------------

	assign ef_fetch = f_fetch & ~last_seen;
	assign ef_align = (fetch_done & ~is_ld) | (f_align & ~exp_equal);
	assign ef_add = f_align & exp_equal;
	// mantissa overflow needs one right shift
	assign ef_fix = f_add & sum_ovf;
	assign ef_norm = (f_add & ~sum_ovf) | f_fix | (f_norm & ~is_norm);
	assign ef_end = (fetch_done & is_ld) | (f_norm & is_norm);

	// strobe class per flag
	always_comb begin
		if (f_fetch)
			state_class = cls_mem;
		else if (f_add)
			state_class = cls_add;
		else if (f_align | f_fix | f_norm)
			state_class = cls_shift;
		else
			state_class = cls_end;
	end

	// ------------------------------------------------------------------------
	// datapath commands
	// ------------------------------------------------------------------------

	assign load_word = f_fetch & strob1;
	assign align_step = f_align & strob1 & ~exp_equal;
	assign add_step = f_add & strob1;
	assign fix_step = f_fix & strob1;
	assign norm_step = f_norm & strob1;
	// ld result goes straight to the accumulator
	assign load_acc = fetch_done & strob2 & is_ld;

	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f) begin
			{f_fetch, f_align, f_add, f_fix, f_norm, f_end} <= '0;
			op_q <= op_ld;
			last_seen <= 1'b0;
			state_entry <= 1'b0;
			fetch_start <= 1'b0;
		end else begin
			state_entry <= 1'b0;
			fetch_start <= 1'b0;
			if (accept) begin
				op_q <= cmd_op;
				last_seen <= 1'b0;
				// nrf skips the fetch
				if (cmd_op == op_nrf) begin
					f_norm <= 1'b1;
					state_entry <= 1'b1;
				end else begin
					f_fetch <= 1'b1;
					fetch_start <= 1'b1;
				end
			end else if (f_end) begin
				if (done_ready)
					f_end <= 1'b0;
			end else if (strob2) begin
				{f_fetch, f_align, f_add, f_fix, f_norm, f_end} <=
					{ef_fetch, ef_align, ef_add, ef_fix, ef_norm, ef_end};
				// fetch re-entry comes from word arrival
				state_entry <= ~ef_end & ~ef_fetch;
			end
			// every arriving word gets its own strobe pass
			if (f_fetch & word_valid) begin
				state_entry <= 1'b1;
				if (fetch_last)
					last_seen <= 1'b1;
			end
		end
	end

	// operand address for the fetch
	always_ff @(posedge clk_sys) begin
		if (accept)
			fetch_addr <= cmd_addr;
	end

endmodule

`default_nettype wire

//--- rtl/fpu_strobe_gen.sv
`default_nettype none

module fpu_strobe_gen #(
	parameter int shift_dly = 1,
	parameter int add_dly = 2
) (
	input logic clk_sys,
	input logic _0_f,
	input logic state_entry,
	input fpu_ctl_pkg::strobe_class_t state_class,
	output logic strob1,
	output logic strob2
);

	import fpu_ctl_pkg::*;

	logic [dly_w-1:0] cnt;
	logic [dly_w-1:0] dly_sel;
	logic armed;

	// per-class delay, picked when the state is entered
	always_comb begin
		unique case (state_class)
			cls_shift: dly_sel = dly_w'(shift_dly);
			cls_add: dly_sel = dly_w'(add_dly);
			cls_mem: dly_sel = dly_w'(fixed_dly);
			cls_end: dly_sel = dly_w'(fixed_dly);
		endcase
	end

	// strob1 on the last count
	assign strob1 = armed && (cnt == dly_w'(1));

	// ------------------------------------------------------------------------
	// delay line
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_sys, posedge _0_f) begin
		if (_0_f) begin
			cnt <= '0;
			armed <= 1'b0;
			strob2 <= 1'b0;
		end else begin
			// strob2 trails strob1 by one clock
			strob2 <= strob1;
			if (state_entry) begin
				cnt <= dly_sel;
				armed <= 1'b1;
			end else if (armed) begin
				cnt <= cnt - 1'b1;
				// one shot per entry
				if (cnt == dly_w'(1))
					armed <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/fpu_top.sv
`default_nettype none

module fpu_top #(
	parameter int shift_dly = 1,
	parameter int add_dly = 2
) (
	input logic clk_sys,
	input logic _0_f,
	input logic cmd_valid,
	input fpu_ctl_pkg::fpu_op_t cmd_op,
	input logic [fpu_fmt_pkg::addr_w-1:0] cmd_addr,
	output logic cmd_ready,
	output logic mem_req_valid,
	output logic [fpu_fmt_pkg::addr_w-1:0] mem_addr,
	input logic mem_req_ready,
	input logic mem_rsp_valid,
	input logic [fpu_fmt_pkg::word_w-1:0] mem_rsp_data,
	output logic done_valid,
	output logic [fpu_fmt_pkg::word_w-1:0] res_w1,
	output logic [fpu_fmt_pkg::word_w-1:0] res_w2,
	output logic [fpu_fmt_pkg::word_w-1:0] res_w3,
	output logic res_ovf,
	output logic res_zero,
	input logic done_ready
);

	import fpu_fmt_pkg::*;
	import fpu_ctl_pkg::*;

	// sequencer to strobe generator
	logic state_entry;
	strobe_class_t state_class;
	logic strob1, strob2;

	// operand fetch
	logic fetch_start;
	logic [addr_w-1:0] fetch_addr;
	logic word_valid, fetch_last;
	logic [idx_w-1:0] word_idx;
	logic [word_w-1:0] word_data;

	// datapath commands and status
	logic load_word, align_step, add_step, fix_step, norm_step, sub_sel, load_acc;
	logic exp_equal, sum_ovf, is_norm;

	fpu_sequencer seq0 (
		.clk_sys(clk_sys), ._0_f(_0_f),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
		.done_ready(done_ready), .strob1(strob1), .strob2(strob2),
		.word_valid(word_valid), .fetch_last(fetch_last),
		.exp_equal(exp_equal), .sum_ovf(sum_ovf), .is_norm(is_norm),
		.cmd_ready(cmd_ready), .done_valid(done_valid),
		.state_entry(state_entry), .state_class(state_class),
		.fetch_start(fetch_start), .fetch_addr(fetch_addr),
		.load_word(load_word), .align_step(align_step), .add_step(add_step),
		.fix_step(fix_step), .norm_step(norm_step), .sub_sel(sub_sel),
		.load_acc(load_acc)
	);

	fpu_strobe_gen #(.shift_dly(shift_dly), .add_dly(add_dly)) strb0 (
		.clk_sys(clk_sys), ._0_f(_0_f),
		.state_entry(state_entry), .state_class(state_class),
		.strob1(strob1), .strob2(strob2)
	);

	fpu_operand_fetch fetch0 (
		.clk_sys(clk_sys), ._0_f(_0_f),
		.fetch_start(fetch_start), .fetch_addr(fetch_addr),
		.mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_data(mem_rsp_data), .mem_req_valid(mem_req_valid),
		.mem_addr(mem_addr), .word_valid(word_valid), .word_idx(word_idx),
		.word_data(word_data), .fetch_last(fetch_last)
	);

	fpu_mant_alu alu0 (
		.clk_sys(clk_sys), ._0_f(_0_f),
		.load_word(load_word), .word_idx(word_idx), .word_data(word_data),
		.load_acc(load_acc), .align_step(align_step), .add_step(add_step),
		.sub_sel(sub_sel), .fix_step(fix_step), .norm_step(norm_step),
		.exp_equal(exp_equal), .sum_ovf(sum_ovf), .is_norm(is_norm),
		.res_w1(res_w1), .res_w2(res_w2), .res_w3(res_w3),
		.res_ovf(res_ovf), .res_zero(res_zero)
	);

endmodule

`default_nettype wire

//--- tb/fpu_tb.sv
`default_nettype none

module fpu_tb;

	import fpu_fmt_pkg::*;
	import fpu_ctl_pkg::*;

	localparam int wait_limit = 4000;
	localparam int mem_words = 256;

	logic clk_sys;
	logic _0_f;
	logic cmd_valid;
	fpu_op_t cmd_op;
	logic [addr_w-1:0] cmd_addr;
	logic cmd_ready;
	logic mem_req_valid;
	logic [addr_w-1:0] mem_addr;
	logic mem_req_ready;
	logic mem_rsp_valid;
	logic [word_w-1:0] mem_rsp_data;
	logic done_valid;
	logic [word_w-1:0] res_w1, res_w2, res_w3;
	logic res_ovf, res_zero;
	logic done_ready;

	// memory model
	logic [word_w-1:0] mem [0:mem_words-1];
	logic mem_stall;
	int rsp_wait = 0;
	int rsp_addr = 0;
	integer seed;
	logic [31:0] mem_rnd;

	// reference accumulator
	logic signed [mant_w-1:0] m_acc;
	logic signed [exp_w-1:0] m_exp;
	logic m_ovf;

	// result as seen at done_valid
	logic [word_w-1:0] got_w1, got_w2, got_w3;
	logic got_ovf, got_zero;

	int errors;
	int timeouts;

	fpu_top #(.shift_dly(1), .add_dly(2)) dut0 (
		.clk_sys(clk_sys), ._0_f(_0_f),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr),
		.cmd_ready(cmd_ready),
		.mem_req_valid(mem_req_valid), .mem_addr(mem_addr),
		.mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
		.mem_rsp_data(mem_rsp_data),
		.done_valid(done_valid), .res_w1(res_w1), .res_w2(res_w2), .res_w3(res_w3),
		.res_ovf(res_ovf), .res_zero(res_zero), .done_ready(done_ready)
	);

	always #50 clk_sys = ~clk_sys;

	// ------------------------------------------------------------------------
	// memory with one read outstanding and a random response delay
	// ------------------------------------------------------------------------

	always @(negedge clk_sys) begin
		mem_rsp_valid = 1'b0;
		if (rsp_wait > 0) begin
			rsp_wait = rsp_wait - 1;
			if (rsp_wait == 0) begin
				mem_rsp_valid = 1'b1;
				mem_rsp_data = mem[rsp_addr];
			end
		end
		// about three in four edges ready under stall
		mem_rnd = $random(seed);
		mem_req_ready = mem_stall ? (mem_rnd[0] | mem_rnd[1]) : 1'b1;
		if (mem_req_valid && mem_req_ready) begin
			if (mem_addr >= addr_w'(mem_words)) begin
				errors++;
				$display("memory read outside the modelled range at %h", mem_addr);
			end
			rsp_addr = int'(mem_addr[7:0]);
			rsp_wait = 1 + int'(mem_rnd[3:2]);
		end
	end

	// ------------------------------------------------------------------------
	// reporting
	// ------------------------------------------------------------------------

	task automatic check_value(input string name, input logic [word_w-1:0] got,
		input logic [word_w-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_and_finish();
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			errors, timeouts, dut0.asrt0.fails);
		if (errors == 0 && timeouts == 0 && dut0.asrt0.fails == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		timeouts++;
		$display("timeout while waiting for %s", what);
		report_and_finish();
	endtask

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------

	task automatic put_operand(input int addr, input logic [mant_w-1:0] m,
		input logic [exp_w-1:0] e);
		mem[addr] = m[mant_w-1 -: word_w];
		mem[addr + 1] = m[mant_w-word_w-1 -: word_w];
		mem[addr + 2] = {m[w3_mant_w-1:0], e};
	endtask

	task automatic read_operand(input int addr, output logic signed [mant_w-1:0] m,
		output logic signed [exp_w-1:0] e);
		m = {mem[addr], mem[addr + 1], mem[addr + 2][word_w-1 -: w3_mant_w]};
		e = mem[addr + 2][exp_w-1:0];
	endtask

	// shift left until the top two bits differ or the mantissa is zero
	task automatic norm_model();
		logic fin;
		fin = 1'b0;
		while (!fin) begin
			if (m_acc == '0) begin
				m_exp = '0;
				fin = 1'b1;
			end else if (m_acc[mant_w-1] != m_acc[mant_w-2])
				fin = 1'b1;
			else if (m_exp === 8'h80) begin
				// underflow below -128
				m_acc = '0;
				m_exp = '0;
			end else begin
				m_acc = m_acc <<< 1;
				m_exp = m_exp - 1;
			end
		end
	endtask

	task automatic addsub_model(input int addr, input logic sub);
		logic signed [mant_w-1:0] om;
		logic signed [exp_w-1:0] oe;
		longint t;
		longint lim;
		int d;
		int k;
		read_operand(addr, om, oe);
		lim = longint'(1) <<< (mant_w - 1);
		d = int'(oe) - int'(m_exp);
		// smaller one shifts right by at most 40 places
		for (k = 0; k < d && k < mant_w; k++)
			m_acc = m_acc >>> 1;
		for (k = 0; k < -d && k < mant_w; k++)
			om = om >>> 1;
		if (d > 0)
			m_exp = oe;
		// signed fractions as whole numbers
		if (sub)
			t = longint'(m_acc) - longint'(om);
		else
			t = longint'(m_acc) + longint'(om);
		m_ovf = 1'b0;
		// out of the fraction range takes one right shift
		if (t >= lim || t < -lim) begin
			t = t >>> 1;
			if (m_exp === 8'h7f)
				m_ovf = 1'b1;
			m_exp = m_exp + 1;
		end
		m_acc = t[mant_w-1:0];
		norm_model();
	endtask

	task automatic apply_model(input fpu_op_t op, input int addr);
		case (op)
			op_ld: begin
				read_operand(addr, m_acc, m_exp);
				m_ovf = 1'b0;
			end
			op_af: addsub_model(addr, 1'b0);
			op_sf: addsub_model(addr, 1'b1);
			default: norm_model();
		endcase
	endtask

	// ------------------------------------------------------------------------
	// command and result handshakes
	// ------------------------------------------------------------------------

	task automatic run_op(input fpu_op_t op, input int addr, input int hold);
		int n;
		cmd_op = op;
		cmd_addr = addr_w'(addr);
		cmd_valid = 1'b1;
		n = 0;
		while (!cmd_ready) begin
			@(negedge clk_sys);
			n++;
			if (n > wait_limit)
				abort_on_timeout("cmd_ready");
		end
		@(negedge clk_sys);
		cmd_valid = 1'b0;
		n = 0;
		while (!done_valid) begin
			@(negedge clk_sys);
			n++;
			if (n > wait_limit)
				abort_on_timeout("done_valid");
		end
		got_w1 = res_w1;
		got_w2 = res_w2;
		got_w3 = res_w3;
		got_ovf = res_ovf;
		got_zero = res_zero;
		// second command knocks while the result is held
		cmd_valid = (hold > 0);
		cmd_op = op_nrf;
		for (n = 0; n < hold; n++) begin
			@(negedge clk_sys);
			check_value("cmd_ready", cmd_ready, 1'b0);
			check_value("done_valid", done_valid, 1'b1);
			check_value("res_w1", res_w1, got_w1);
			check_value("res_w2", res_w2, got_w2);
			check_value("res_w3", res_w3, got_w3);
		end
		cmd_valid = 1'b0;
		done_ready = 1'b1;
		@(negedge clk_sys);
		done_ready = 1'b0;
		check_value("done_valid", done_valid, 1'b0);
	endtask

	task automatic exec_and_check(input fpu_op_t op, input int addr, input int hold);
		run_op(op, addr, hold);
		apply_model(op, addr);
		check_value("res_w1", got_w1, m_acc[mant_w-1 -: word_w]);
		check_value("res_w2", got_w2, m_acc[mant_w-word_w-1 -: word_w]);
		check_value("res_w3", got_w3, {m_acc[w3_mant_w-1:0], m_exp});
		check_value("res_ovf", got_ovf, m_ovf);
		check_value("res_zero", got_zero, m_acc == '0);
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------

	task automatic reset_state();
		check_value("cmd_ready", cmd_ready, 1'b1);
		check_value("mem_req_valid", mem_req_valid, 1'b0);
		check_value("done_valid", done_valid, 1'b0);
	endtask

	task automatic load_cases();
		put_operand(0, 40'h5a3c12349f, 8'h05);
		put_operand(3, 40'ha000000001, 8'hfd);
		exec_and_check(op_ld, 0, 0);
		check_value("res_w3", got_w3, 16'h9f05);
		exec_and_check(op_ld, 3, 2);
	endtask

	task automatic add_cases();
		put_operand(10, 40'h4000000000, 8'h02);
		put_operand(13, 40'h4000000000, 8'h02);
		put_operand(16, 40'h6000000000, 8'h04);
		put_operand(19, 40'h4000000001, 8'h01);
		put_operand(22, 40'hb000000000, 8'h00);
		// equal exponents where the sum overflows and is fixed
		exec_and_check(op_ld, 10, 0);
		exec_and_check(op_af, 13, 1);
		check_value("res_w3", got_w3, 16'h0003);
		// unequal exponents with the operand aligned by three
		exec_and_check(op_ld, 16, 0);
		exec_and_check(op_af, 19, 0);
		check_value("res_w1", got_w1, 16'h6800);
		exec_and_check(op_af, 22, 0);
	endtask

	task automatic sub_cases();
		put_operand(25, 40'h5000000000, 8'h00);
		put_operand(28, 40'h4800000000, 8'h00);
		exec_and_check(op_ld, 16, 0);
		exec_and_check(op_sf, 16, 0);
		check_value("res_w3", got_w3, 16'h0000);
		check_value("res_zero", got_zero, 1'b1);
		// partial cancellation needing three left shifts
		exec_and_check(op_ld, 25, 0);
		exec_and_check(op_sf, 28, 0);
		check_value("res_w1", got_w1, 16'h4000);
		check_value("res_w3", got_w3, 16'h00fd);
	endtask

	task automatic norm_ovf_cases();
		put_operand(31, 40'h0300000000, 8'h0a);
		put_operand(34, 40'h0000000001, 8'h82);
		put_operand(37, 40'h4000000000, 8'h7f);
		exec_and_check(op_ld, 31, 0);
		exec_and_check(op_nrf, 0, 0);
		check_value("res_w1", got_w1, 16'h6000);
		check_value("res_w3", got_w3, 16'h0005);
		// exponent runs below -128
		exec_and_check(op_ld, 34, 0);
		exec_and_check(op_nrf, 0, 0);
		check_value("res_zero", got_zero, 1'b1);
		// exponent wraps past +127
		exec_and_check(op_ld, 37, 0);
		exec_and_check(op_af, 37, 0);
		check_value("res_ovf", got_ovf, 1'b1);
		check_value("res_w3", got_w3, 16'h0080);
		exec_and_check(op_nrf, 0, 0);
		exec_and_check(op_ld, 0, 0);
	endtask

	task automatic stall_stress();
		int i;
		int ri;
		logic [31:0] r;
		logic [63:0] wide;
		mem_stall = 1'b1;
		for (i = 0; i < 8; i++) begin
			wide = {$random(seed), $random(seed)};
			ri = $random(seed);
			put_operand(100 + 3 * i, wide[mant_w-1:0], exp_w'(ri % 21));
		end
		exec_and_check(op_ld, 100, 0);
		for (i = 0; i < 16; i++) begin
			r = $random(seed);
			exec_and_check(fpu_op_t'(r[1:0]), 100 + 3 * int'(r[4:2]), int'(r[7:5]));
		end
		mem_stall = 1'b0;
	endtask

	initial begin
		clk_sys = 1'b0;
		_0_f = 1'b1;
		cmd_valid = 1'b0;
		cmd_op = op_ld;
		cmd_addr = '0;
		mem_req_ready = 1'b0;
		mem_rsp_valid = 1'b0;
		mem_rsp_data = '0;
		done_ready = 1'b0;
		mem_stall = 1'b0;
		seed = 99176;
		errors = 0;
		timeouts = 0;
		m_acc = '0;
		m_exp = '0;
		m_ovf = 1'b0;
		// background words distinct at every address
		for (int i = 0; i < mem_words; i++)
			mem[i] = {8'(i) ^ 8'h5a, 8'(i)};
		repeat (10) @(negedge clk_sys);
		_0_f = 1'b0;
		@(negedge clk_sys);
		reset_state();
		load_cases();
		add_cases();
		sub_cases();
		norm_ovf_cases();
		stall_stress();
		report_and_finish();
	end

endmodule

`default_nettype wire

//--- tb/fpu_tb_asserts.sv
`default_nettype none

module fpu_tb_asserts (
	input logic clk_sys,
	input logic _0_f,
	input logic cmd_ready,
	input logic mem_req_valid,
	input logic mem_req_ready,
	input logic [fpu_fmt_pkg::addr_w-1:0] mem_addr,
	input logic done_valid,
	input logic done_ready,
	input logic [fpu_fmt_pkg::word_w-1:0] res_w1,
	input logic [fpu_fmt_pkg::word_w-1:0] res_w2,
	input logic [fpu_fmt_pkg::word_w-1:0] res_w3,
	input logic res_ovf,
	input logic res_zero
);

	// failed assertion count
	int fails = 0;

	// ------------------------------------------------------------------------
	// handshake stability
	// ------------------------------------------------------------------------

	// read request held while memory stalls
	req_hold: assert property (@(posedge clk_sys) disable iff (_0_f)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_addr))
		else begin
			fails++;
			$error("memory request dropped or moved during stall");
		end

	// result frozen until taken
	res_hold: assert property (@(posedge clk_sys) disable iff (_0_f)
		done_valid && !done_ready |=> done_valid
		&& $stable({res_w1, res_w2, res_w3, res_ovf, res_zero}))
		else begin
			fails++;
			$error("result dropped or changed before it was taken");
		end

	// busy from acceptance until the result is taken
	busy_end: assert property (@(posedge clk_sys) disable iff (_0_f)
		!cmd_ready && !(done_valid && done_ready) |=> !cmd_ready)
		else begin
			fails++;
			$error("cmd_ready rose before the result was taken");
		end

endmodule

bind fpu_top fpu_tb_asserts asrt0 (
	.clk_sys(clk_sys),
	._0_f(_0_f),
	.cmd_ready(cmd_ready),
	.mem_req_valid(mem_req_valid),
	.mem_req_ready(mem_req_ready),
	.mem_addr(mem_addr),
	.done_valid(done_valid),
	.done_ready(done_ready),
	.res_w1(res_w1),
	.res_w2(res_w2),
	.res_w3(res_w3),
	.res_ovf(res_ovf),
	.res_zero(res_zero)
);

`default_nettype wire
